// File: common/fpuVecPkg.sv
// ==============================
// shared types and constants for the four-lane SIMD FPU
// operation and format codes, the 64-bit register word seen as
// singles or halves, the shuffle control and the issue/result
// bundles exchanged with the execute stage
// modules take these by a wildcard import in their header
// ==============================

package fpuVecPkg;

	// lane count is fixed by the 64-bit word of four halves
	localparam int vecLanes = 4;

	// issue to result, in enabled clock edges
	localparam int vecLatency = 2;

	// quiet NaN patterns produced for any NaN or infinity input
	localparam logic [31:0] fpCanonNaN = 32'h7FC0_0000;
	localparam logic [15:0] fpHalfCanonNaN = 16'h7E00;

	typedef enum logic [1:0]
	{
		opAdd = 2'd0,
		opSub = 2'd1,
		opMul = 2'd2
	} vecOpT;

	typedef enum logic
	{
		fmtSingle = 1'b0,
		fmtHalf = 1'b1
	} vecFmtT;

	// one register word, read as two singles or four halves
	// element 0 sits in the low bits in both views
	typedef union packed
	{
		logic [1:0][31:0] sf;
		logic [3:0][15:0] hf;
	} vecWordT;

	typedef logic [1:0] laneSelT;

	// sel[i] names the source lane for destination lane i
	typedef struct packed
	{
		logic en;
		laneSelT [vecLanes-1:0] sel;
	} shuffleT;

	typedef struct packed
	{
		logic valid;
		vecOpT op;
		vecFmtT fmt;
		shuffleT shufRs;
		shuffleT shufRt;
	} vecIssueT;

	// in half format lo and hi carry the same word
	typedef struct packed
	{
		logic valid;
		vecWordT lo;
		vecWordT hi;
	} vecResultT;

endpackage

// File: dv/fpuVecTb.sv
// ==============================
// directed testbench for the four-lane SIMD FPU
// operands are quarter-step values so every result is exact;
// expected words come from real arithmetic and local encoders
// outputs are checked on each falling edge against a FIFO of
// pending issues, aged by enabled clock edges
// ==============================

`timescale 1ns/1ps

module fpuVecTb import fpuVecPkg::*;
();

	localparam int issueCount = 20;
	localparam int heldCycles = 3;
	localparam int cycleLimit = 4 + issueCount * (vecLatency + 1) + heldCycles + 40;

	logic clock;
	logic rst;
	logic hold;
	vecIssueT issue;
	vecWordT rsLo;
	vecWordT rsHi;
	vecWordT rtLo;
	vecWordT rtHi;
	vecResultT result;

	real srcA [4];
	real srcB [4];
	logic [31:0] rngState;
	int cycleCount;
	int checkErrors;
	int otherErrors;
	vecResultT lastResult;
	vecResultT pendExp [$];
	int pendAge [$];
	string pendTag [$];

	fpuVec4SF i_dut
	(
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.issue(issue),
		.rsLo(rsLo),
		.rsHi(rsHi),
		.rtLo(rtLo),
		.rtHi(rtHi),
		.result(result)
	);

	bind fpuVec4SF fpuVec_assertions i_checks
	(
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.issue(issue),
		.result(result)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// multiples of 0.25 in [-8, 7.75]
	function automatic real randomQuarter();
		int k;
		k = int'(nextRandom() % 32'd64) - 32;
		return k / 4.0;
	endfunction

	function automatic logic [31:0] encodeSingle(input real r);
		logic [63:0] d;
		int e;
		d = $realtobits(r);
		e = int'(d[62:52]);
		if (e == 2047)
			return fpCanonNaN;
		if (e == 0)
			return {d[63], 31'd0};
		e = e - 1023 + 127;
		if (e >= 255)
			return {d[63], 8'hFF, 23'd0};
		if (e <= 0)
			return {d[63], 31'd0};
		return {d[63], e[7:0], d[51:29]};
	endfunction

	function automatic logic [15:0] encodeHalf(input real r);
		logic [63:0] d;
		int e;
		d = $realtobits(r);
		e = int'(d[62:52]);
		if (e == 2047)
			return fpHalfCanonNaN;
		if (e == 0)
			return {d[63], 15'd0};
		e = e - 1023 + 15;
		if (e >= 31)
			return {d[63], 5'h1F, 10'd0};
		if (e <= 0)
			return {d[63], 15'd0};
		return {d[63], e[4:0], d[51:42]};
	endfunction

	function automatic shuffleT makeShuffle(input logic en, input laneSelT s0,
		input laneSelT s1, input laneSelT s2, input laneSelT s3);
		shuffleT s;
		s.en = en;
		s.sel[0] = s0;
		s.sel[1] = s1;
		s.sel[2] = s2;
		s.sel[3] = s3;
		return s;
	endfunction

	task automatic checkWord(input vecWordT got, input vecWordT exp, input string what);
		if (got !== exp)
		begin
			checkErrors++;
			$display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkResult(input vecResultT got, input vecResultT exp, input string what);
		if (got.valid !== exp.valid)
		begin
			checkErrors++;
			$display("CHECK FAILED @%0t: %s valid got %b expected %b", $time, what,
				got.valid, exp.valid);
		end
		checkWord(got.lo, exp.lo, {what, " lo"});
		checkWord(got.hi, exp.hi, {what, " hi"});
	endtask

	task automatic fillRandom();
		for (int i = 0; i < 4; i++)
		begin
			srcA[i] = randomQuarter();
			srcB[i] = randomQuarter();
		end
	endtask

	// drives one issue from srcA/srcB and queues its expected result
	task automatic issueReals(input vecOpT op, input vecFmtT fmt, input shuffleT shRs,
		input shuffleT shRt, input string tag);
		vecResultT exp;
		logic [3:0][31:0] sfOut;
		logic [3:0][15:0] hfOut;
		real ra;
		real rb;
		real rr;
		int ia;
		int ib;
		for (int i = 0; i < 4; i++)
		begin
			ia = shRs.en ? int'(shRs.sel[i]) : i;
			ib = shRt.en ? int'(shRt.sel[i]) : i;
			ra = srcA[ia];
			rb = srcB[ib];
			if (op == opMul)
				rr = ra * rb;
			else if (op == opSub)
				rr = ra - rb;
			else
				rr = ra + rb;
			sfOut[i] = encodeSingle(rr);
			hfOut[i] = encodeHalf(rr);
		end
		exp.valid = 1'b1;
		if (fmt == fmtHalf)
		begin
			exp.lo.hf = hfOut;
			exp.hi.hf = hfOut;
			for (int i = 0; i < 4; i++)
			begin
				rsLo.hf[i] = encodeHalf(srcA[i]);
				rtLo.hf[i] = encodeHalf(srcB[i]);
			end
			// hi words must be ignored in half format
			rsHi = {nextRandom(), nextRandom()};
			rtHi = {nextRandom(), nextRandom()};
		end
		else
		begin
			exp.lo.sf = sfOut[1:0];
			exp.hi.sf = sfOut[3:2];
			rsLo.sf[0] = encodeSingle(srcA[0]);
			rsLo.sf[1] = encodeSingle(srcA[1]);
			rsHi.sf[0] = encodeSingle(srcA[2]);
			rsHi.sf[1] = encodeSingle(srcA[3]);
			rtLo.sf[0] = encodeSingle(srcB[0]);
			rtLo.sf[1] = encodeSingle(srcB[1]);
			rtHi.sf[0] = encodeSingle(srcB[2]);
			rtHi.sf[1] = encodeSingle(srcB[3]);
		end
		issue.valid = 1'b1;
		issue.op = op;
		issue.fmt = fmt;
		issue.shufRs = shRs;
		issue.shufRt = shRt;
		// an issue under hold is dropped by the DUT
		if (!hold)
		begin
			pendExp.push_back(exp);
			pendAge.push_back(0);
			pendTag.push_back(tag);
		end
	endtask

	// one clock, then check the outputs on the falling edge
	task automatic tick();
		logic edgeEnabled;
		@(negedge clock);
		edgeEnabled = !hold;
		if (edgeEnabled)
		begin
			foreach (pendAge[i])
				pendAge[i] = pendAge[i] + 1;
			if (pendAge.size() > 0 && pendAge[0] == vecLatency)
			begin
				if (result.valid !== 1'b1)
				begin
					otherErrors++;
					$display("%s: no result valid %0d cycles after the issue (time %0t)",
						pendTag[0], vecLatency, $time);
				end
				else
				begin
					checkResult(result, pendExp[0], pendTag[0]);
				end
				void'(pendExp.pop_front());
				void'(pendAge.pop_front());
				void'(pendTag.pop_front());
			end
			else if (result.valid !== 1'b0)
			begin
				otherErrors++;
				$display("result valid high with no result due at time %0t", $time);
			end
		end
		else
		begin
			checkResult(result, lastResult, "held result");
		end
		lastResult = result;
		issue.valid = 1'b0;
	endtask

	task automatic drain();
		while (pendAge.size() > 0)
			tick();
	endtask

	task automatic singleOps();
		shuffleT none;
		none = makeShuffle(1'b0, 2'd0, 2'd0, 2'd0, 2'd0);
		fillRandom();
		issueReals(opAdd, fmtSingle, none, none, "single add");
		drain();
		fillRandom();
		issueReals(opSub, fmtSingle, none, none, "single sub");
		drain();
		fillRandom();
		issueReals(opMul, fmtSingle, none, none, "single mul");
		drain();
	endtask

	task automatic halfOps();
		shuffleT none;
		none = makeShuffle(1'b0, 2'd0, 2'd0, 2'd0, 2'd0);
		fillRandom();
		issueReals(opAdd, fmtHalf, none, none, "half add");
		drain();
		fillRandom();
		issueReals(opSub, fmtHalf, none, none, "half sub");
		drain();
		fillRandom();
		issueReals(opMul, fmtHalf, none, none, "half mul");
		drain();
	endtask

	task automatic laneShuffles();
		shuffleT none;
		shuffleT reverse;
		shuffleT bcast;
		shuffleT disabled;
		none = makeShuffle(1'b0, 2'd0, 2'd0, 2'd0, 2'd0);
		reverse = makeShuffle(1'b1, 2'd3, 2'd2, 2'd1, 2'd0);
		bcast = makeShuffle(1'b1, 2'd0, 2'd0, 2'd0, 2'd0);
		disabled = makeShuffle(1'b0, 2'd2, 2'd3, 2'd0, 2'd1);
		fillRandom();
		issueReals(opAdd, fmtSingle, reverse, none, "shuffle rs reverse");
		drain();
		fillRandom();
		issueReals(opMul, fmtSingle, none, bcast, "shuffle rt broadcast");
		drain();
		fillRandom();
		issueReals(opSub, fmtHalf, reverse, bcast, "shuffle both half");
		drain();
		fillRandom();
		issueReals(opAdd, fmtSingle, disabled, disabled, "shuffle disabled");
		drain();
	endtask

	task automatic backToBackIssues();
		shuffleT none;
		none = makeShuffle(1'b0, 2'd0, 2'd0, 2'd0, 2'd0);
		fillRandom();
		issueReals(opAdd, fmtSingle, none, none, "burst 0");
		tick();
		fillRandom();
		issueReals(opMul, fmtHalf, none, none, "burst 1");
		tick();
		fillRandom();
		issueReals(opSub, fmtSingle, makeShuffle(1'b1, 2'd1, 2'd0, 2'd3, 2'd2), none,
			"burst 2");
		tick();
		fillRandom();
		issueReals(opMul, fmtSingle, none, none, "burst 3");
		drain();
	endtask

	task automatic holdMidFlight();
		shuffleT none;
		none = makeShuffle(1'b0, 2'd0, 2'd0, 2'd0, 2'd0);
		fillRandom();
		issueReals(opAdd, fmtSingle, none, none, "hold first");
		tick();
		fillRandom();
		issueReals(opMul, fmtHalf, none, none, "hold second");
		tick();
		// second item sits in stage one while frozen
		hold = 1'b1;
		fillRandom();
		issueReals(opSub, fmtSingle, none, none, "dropped under hold");
		repeat (heldCycles)
			tick();
		hold = 1'b0;
		drain();
	endtask

	task automatic specialValues();
		shuffleT none;
		none = makeShuffle(1'b0, 2'd0, 2'd0, 2'd0, 2'd0);
		fillRandom();
		srcA[0] = $bitstoreal(64'h7FF8_0000_0000_0000);
		issueReals(opAdd, fmtSingle, none, none, "nan input");
		drain();
		srcA[0] = 200.0;
		srcA[1] = 3.0;
		srcA[2] = -2.0;
		srcA[3] = 0.5;
		srcB[0] = 400.0;
		srcB[1] = 5.0;
		srcB[2] = 1.5;
		srcB[3] = -4.0;
		issueReals(opMul, fmtHalf, none, none, "half overflow");
		drain();
		srcA[0] = 2.5;
		srcA[1] = -7.0;
		srcA[2] = 0.25;
		srcA[3] = 12.0;
		for (int i = 0; i < 4; i++)
			srcB[i] = -srcA[i];
		issueReals(opAdd, fmtSingle, none, none, "exact cancel");
		drain();
	endtask

	initial
	begin
		rst = 1'b1;
		hold = 1'b0;
		issue = '0;
		rsLo = '0;
		rsHi = '0;
		rtLo = '0;
		rtHi = '0;
		rngState = 32'd50;
		cycleCount = 0;
		checkErrors = 0;
		otherErrors = 0;
		repeat (4) @(negedge clock);
		rst = 1'b0;
		if (result.valid !== 1'b0)
		begin
			otherErrors++;
			$display("result valid is not low after reset (time %0t)", $time);
		end
		lastResult = result;
		singleOps();
		halfOps();
		laneShuffles();
		backToBackIssues();
		holdMidFlight();
		specialValues();
		$display("value mismatches: %0d, other failures: %0d", checkErrors, otherErrors);
		if (checkErrors == 0 && otherErrors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: dv/fpuVec_assertions.sv
// ==============================
// pipeline checks for the SIMD FPU top level
// attached to every fpuVec4SF by bind from the testbench
// ==============================

`timescale 1ns/1ps

module fpuVec_assertions import fpuVecPkg::*;
(
	input logic clock,
	input logic rst,
	input logic hold,
	input vecIssueT issue,
	input vecResultT result
);

	// a held pipeline must not move
	holdFreezesResult: assert property (@(posedge clock) disable iff (rst)
		hold |=> $stable(result))
		else $error("result changed while hold was high");

	// staged valids are cleared by reset
	validLowAfterReset: assert property (@(posedge clock)
		$fell(rst) |-> !result.valid)
		else $error("result valid high in the cycle after reset");

	// two enabled edges from issue to result
	issueGivesResult: assert property (@(posedge clock) disable iff (rst)
		(issue.valid && !hold) ##1 !hold |=> result.valid)
		else $error("no result valid two cycles after an accepted issue");

endmodule

// File: fpuVec/fpuAddSF.sv
// ==============================
// two-stage single-precision add/subtract for one lane
// stage one swaps by magnitude and aligns the smaller operand,
// stage two adds, normalizes and truncates toward zero
// hold freezes both stages; sub negates b
// ==============================

`timescale 1ns/1ps

module fpuAddSF import fpuVecPkg::*;
(
	input logic clock,
	input logic rst,
	input logic hold,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic sub,
	output logic [31:0] sum
);

	logic [31:0] bEff;
	logic [30:0] aMag;
	logic [30:0] bMag;
	logic [30:0] xMag;
	logic [30:0] yMag;
	logic aLarger;
	logic special;
	logic [7:0] expDiff;
	logic [26:0] mantX;
	logic [26:0] mantY;

	// stage one registers
	logic nan1;
	logic opDiff1;
	logic sign1;
	logic [7:0] exp1;
	logic [26:0] mantX1;
	logic [26:0] mantY1;

	// stage two datapath
	logic [27:0] rawSum;
	logic [4:0] lz;
	logic [26:0] normShift;
	logic signed [9:0] expNorm;
	logic [22:0] mantOut;
	logic [31:0] sumNext;

	function automatic logic [4:0] lzc27(input logic [26:0] v);
		logic [4:0] n;
		logic found;
		n = 5'd0;
		found = 1'b0;
		for (int i = 26; i >= 0; i--)
		begin
			if (v[i])
				found = 1'b1;
			else if (!found)
				n = n + 5'd1;
		end
		return n;
	endfunction

	assign bEff = {b[31] ^ sub, b[30:0]};
	assign special = (a[30:23] == 8'hFF) || (b[30:23] == 8'hFF);

	// denormals flush, so a zero exponent means a zero magnitude
	assign aMag = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];
	assign bMag = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
	assign aLarger = aMag >= bMag;
	assign xMag = aLarger ? aMag : bMag;
	assign yMag = aLarger ? bMag : aMag;

	// hidden bit on top, three guard bits below
	assign mantX = {xMag[30:23] != 8'd0, xMag[22:0], 3'b000};
	assign mantY = {yMag[30:23] != 8'd0, yMag[22:0], 3'b000};
	assign expDiff = xMag[30:23] - yMag[30:23];

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			nan1 <= 1'b0;
			opDiff1 <= 1'b0;
		end
		else if (!hold)
		begin
			nan1 <= special;
			opDiff1 <= a[31] ^ bEff[31];
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			sign1 <= aLarger ? a[31] : bEff[31];
			exp1 <= xMag[30:23];
			mantX1 <= mantX;
			// bits shifted out are simply lost
			mantY1 <= (expDiff > 8'd26) ? 27'd0 : (mantY >> expDiff);
		end
	end

	// x is never smaller than the aligned y, so no negative result
	assign rawSum = opDiff1 ? ({1'b0, mantX1} - {1'b0, mantY1}) :
		({1'b0, mantX1} + {1'b0, mantY1});
	assign lz = lzc27(rawSum[26:0]);
	assign normShift = rawSum[26:0] << lz;

	always_comb
	begin
		if (rawSum[27])
		begin
			expNorm = $signed({2'b00, exp1}) + 10'sd1;
			mantOut = rawSum[26:4];
		end
		else
		begin
			expNorm = $signed({2'b00, exp1}) - $signed({5'd0, lz});
			mantOut = normShift[25:3];
		end

		if (nan1)
			sumNext = fpCanonNaN;
		else if (rawSum == 28'd0)
			sumNext = 32'd0;
		else if (expNorm <= 0)
			sumNext = {sign1, 31'd0};
		else if (expNorm >= 255)
			sumNext = {sign1, 8'hFF, 23'd0};
		else
			sumNext = {sign1, expNorm[7:0], mantOut};
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			sum <= sumNext;
	end

endmodule

// File: fpuVec/fpuConvH2S.sv
// ==============================
// widens one half-precision value to single precision
// purely combinational, used on every half operand lane
// ==============================

`timescale 1ns/1ps

module fpuConvH2S import fpuVecPkg::*;
(
	input logic [15:0] half,
	output logic [31:0] single
);

	logic [4:0] expHalf;
	logic [7:0] expSingle;

	assign expHalf = half[14:10];

	// rebias from 15 to 127
	assign expSingle = {3'b000, expHalf} + 8'd112;

	always_comb
	begin
		if (expHalf == 5'd0)
		begin
			// zero and denormals both flush to a signed zero
			single = {half[15], 31'd0};
		end
		else if (expHalf == 5'h1F)
		begin
			single = fpCanonNaN;
		end
		else
		begin
			single = {half[15], expSingle, half[9:0], 13'd0};
		end
	end

endmodule

// File: fpuVec/fpuConvS2H.sv
// ==============================
// narrows one single-precision value to half precision
// mantissa is truncated; values under the half range flush
// to signed zero and values over it saturate to infinity
// purely combinational, used on the result lanes
// ==============================

`timescale 1ns/1ps

module fpuConvS2H import fpuVecPkg::*;
(
	input logic [31:0] single,
	output logic [15:0] half
);

	logic [7:0] expSingle;
	logic signed [9:0] expHalf;

	assign expSingle = single[30:23];

	// signed rebias from 127 to 15 so underflow goes negative
	assign expHalf = $signed({2'b00, expSingle}) - 10'sd112;

	always_comb
	begin
		if (expSingle == 8'hFF)
		begin
			half = fpHalfCanonNaN;
		end
		else if (expHalf <= 0)
		begin
			// also catches single zeros and flushed denormals
			half = {single[31], 15'd0};
		end
		else if (expHalf >= 31)
		begin
			half = {single[31], 5'h1F, 10'd0};
		end
		else
		begin
			half = {single[31], expHalf[4:0], single[22:13]};
		end
	end

endmodule

// File: fpuVec/fpuMulSF.sv
// ==============================
// two-stage single-precision multiply for one lane
// stage one forms the full mantissa product and exponent,
// stage two normalizes by one bit and truncates toward zero
// hold freezes both stages
// ==============================

`timescale 1ns/1ps

module fpuMulSF import fpuVecPkg::*;
(
	input logic clock,
	input logic rst,
	input logic hold,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] prod
);

	logic [23:0] mantA;
	logic [23:0] mantB;

	// stage one registers
	logic nan1;
	logic zero1;
	logic sign1;
	logic signed [9:0] expSum1;
	logic [47:0] prod1;

	logic signed [9:0] expNorm;
	logic [22:0] mantOut;
	logic [31:0] prodNext;

	assign mantA = {1'b1, a[22:0]};
	assign mantB = {1'b1, b[22:0]};

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			nan1 <= 1'b0;
			zero1 <= 1'b0;
		end
		else if (!hold)
		begin
			nan1 <= (a[30:23] == 8'hFF) || (b[30:23] == 8'hFF);
			zero1 <= (a[30:23] == 8'd0) || (b[30:23] == 8'd0);
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			sign1 <= a[31] ^ b[31];
			expSum1 <= $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - 10'sd127;
			prod1 <= mantA * mantB;
		end
	end

	always_comb
	begin
		// product of two 1.x mantissas lies in [1, 4)
		if (prod1[47])
		begin
			expNorm = expSum1 + 10'sd1;
			mantOut = prod1[46:24];
		end
		else
		begin
			expNorm = expSum1;
			mantOut = prod1[45:23];
		end

		if (nan1)
			prodNext = fpCanonNaN;
		else if (zero1 || (expNorm <= 0))
			prodNext = {sign1, 31'd0};
		else if (expNorm >= 255)
			prodNext = {sign1, 8'hFF, 23'd0};
		else
			prodNext = {sign1, expNorm[7:0], mantOut};
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			prod <= prodNext;
	end

endmodule

// File: fpuVec/fpuVec4SF.sv
// ==============================
// four-lane SIMD FPU, top level
// one issue strobe starts an add, subtract or multiply on four
// singles (rsLo/rsHi, rtLo/rtHi) or four halves (rsLo, rtLo)
// result appears two enabled clocks later; hold freezes all
// ==============================

`timescale 1ns/1ps

module fpuVec4SF import fpuVecPkg::*;
(
	input logic clock,
	input logic rst,
	input logic hold,
	input vecIssueT issue,
	input vecWordT rsLo,
	input vecWordT rsHi,
	input vecWordT rtLo,
	input vecWordT rtHi,
	output vecResultT result
);

	typedef struct packed
	{
		logic valid;
		vecOpT op;
		vecFmtT fmt;
	} ctrlT;

	logic [vecLanes-1:0][31:0] rsWide;
	logic [vecLanes-1:0][31:0] rtWide;
	logic [vecLanes-1:0][31:0] rsLane;
	logic [vecLanes-1:0][31:0] rtLane;
	logic [vecLanes-1:0][31:0] rsShuf;
	logic [vecLanes-1:0][31:0] rtShuf;
	logic [vecLanes-1:0][31:0] addOut;
	logic [vecLanes-1:0][31:0] mulOut;
	logic [vecLanes-1:0][31:0] laneOut;
	logic [vecLanes-1:0][15:0] halfOut;
	logic isHalf;
	logic isSub;

	ctrlT ctrlIn;
	ctrlT [vecLatency-1:0] ctrlPipe;
	ctrlT ctrlOut;

	assign isHalf = issue.fmt == fmtHalf;
	assign isSub = issue.op == opSub;

	genvar i;
	generate
		for (i = 0; i < vecLanes; i++)
		begin : g_lane
			fpuConvH2S i_h2sRs (.half(rsLo.hf[i]), .single(rsWide[i]));
			fpuConvH2S i_h2sRt (.half(rtLo.hf[i]), .single(rtWide[i]));

			// single format takes lanes 0,1 from lo and lanes 2,3 from hi
			assign rsLane[i] = isHalf ? rsWide[i] :
				((i < 2) ? rsLo.sf[i % 2] : rsHi.sf[i % 2]);
			assign rtLane[i] = isHalf ? rtWide[i] :
				((i < 2) ? rtLo.sf[i % 2] : rtHi.sf[i % 2]);

			fpuAddSF i_add
			(
				.clock(clock),
				.rst(rst),
				.hold(hold),
				.a(rsShuf[i]),
				.b(rtShuf[i]),
				.sub(isSub),
				.sum(addOut[i])
			);

			fpuMulSF i_mul
			(
				.clock(clock),
				.rst(rst),
				.hold(hold),
				.a(rsShuf[i]),
				.b(rtShuf[i]),
				.prod(mulOut[i])
			);

			assign laneOut[i] = (ctrlOut.op == opMul) ? mulOut[i] : addOut[i];

			fpuConvS2H i_s2h (.single(laneOut[i]), .half(halfOut[i]));
		end
	endgenerate

	fpuVecShuffle i_shufRs (.lanes(rsLane), .shuf(issue.shufRs), .lanesOut(rsShuf));
	fpuVecShuffle i_shufRt (.lanes(rtLane), .shuf(issue.shufRt), .lanesOut(rtShuf));

	// control rides alongside the lane pipelines
	assign ctrlIn = '{valid: issue.valid, op: issue.op, fmt: issue.fmt};
	assign ctrlOut = ctrlPipe[vecLatency-1];

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int s = 0; s < vecLatency; s++)
				ctrlPipe[s].valid <= 1'b0;
		end
		else if (!hold)
		begin
			ctrlPipe[0] <= ctrlIn;
			for (int s = 1; s < vecLatency; s++)
				ctrlPipe[s] <= ctrlPipe[s-1];
		end
	end

	always_comb
	begin
		result.valid = ctrlOut.valid;
		if (ctrlOut.fmt == fmtHalf)
		begin
			// halves go out on both words
			result.lo.hf = halfOut;
			result.hi.hf = halfOut;
		end
		else
		begin
			result.lo.sf = laneOut[1:0];
			result.hi.sf = laneOut[3:2];
		end
	end

endmodule

// File: fpuVec/fpuVecShuffle.sv
// ==============================
// four-lane permute of one operand vector
// destination lane i takes source lane sel[i] when enabled,
// otherwise every lane keeps its own value
// ==============================

`timescale 1ns/1ps

module fpuVecShuffle import fpuVecPkg::*;
(
	input logic [vecLanes-1:0][31:0] lanes,
	input shuffleT shuf,
	output logic [vecLanes-1:0][31:0] lanesOut
);

	always_comb
	begin
		for (int i = 0; i < vecLanes; i++)
		begin
			if (shuf.en)
			begin
				lanesOut[i] = lanes[shuf.sel[i]];
			end
			else
			begin
				lanesOut[i] = lanes[i];
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# builds the SIMD FPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fpuVecTb -f vlog.f -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
	exit 0
fi
echo "pass message not found"
exit 1

// File: vlog.f
common/fpuVecPkg.sv
fpuVec/fpuConvH2S.sv
fpuVec/fpuConvS2H.sv
fpuVec/fpuVecShuffle.sv
fpuVec/fpuAddSF.sv
fpuVec/fpuMulSF.sv
fpuVec/fpuVec4SF.sv
dv/fpuVec_assertions.sv
dv/fpuVecTb.sv
